//--- Bender.yml
package:
  name: rs_issue

sources:
  - files:
      - rs_pkg.sv
      - rs_reg_trk.sv
      - rs_entry.sv
      - rs_pick.sv
      - rs_top.sv
  - target: test
    files:
      - rs_chk.sv
      - rs_tb.sv

//--- rs_chk.sv
`timescale 1ns/1ps

module rs_chk (
   input logic                              clk,
   input logic                              reset,
   input logic                              alloc_valid,
   input logic                              issue_valid,
   input logic                              credit_return,
   input logic [rs_pkg::RS_NUM_ENTRIES-1:0] grant,
   input logic [rs_pkg::RS_NUM_ENTRIES-1:0] entry_valid
);

   // the granted slot must be gone from the valid set one cycle later
   a_grant_onehot: assert property (@(posedge clk) disable iff (reset)
      issue_valid |=> $onehot($past(grant)) && ((entry_valid & $past(grant)) == '0))
      else $error("grant not one-hot or granted slot still valid after issue");

   // occupancy grows by allocations and shrinks by returned credits
   a_credit_issue: assert property (@(posedge clk) disable iff (reset)
      $countones(entry_valid) + $past(credit_return) ==
      $past($countones(entry_valid)) + $past(alloc_valid))
      else $error("credit_return does not match the slots released");

   // credit protocol keeps the sender off a full station
   a_no_overflow: assert property (@(posedge clk) disable iff (reset)
      alloc_valid |-> !(&entry_valid))
      else $error("allocation while every entry is valid");

   a_reset_quiet: assert property (@(posedge clk)
      reset && $past(reset) |-> !issue_valid)
      else $error("issue_valid high during reset");

endmodule

bind rs_top rs_chk chk_i (
   .clk           (clk),
   .reset         (reset),
   .alloc_valid   (alloc_valid),
   .issue_valid   (issue_valid),
   .credit_return (credit_return),
   .grant         (grant),
   .entry_valid   (entry_valid)
);

//--- rs_entry.sv
`timescale 1ns/1ps

module rs_entry (
   input  logic                  clk,
   input  logic                  reset,

   input  logic                  alloc,
   input  rs_pkg::t_rs_alloc_pkt alloc_pkt,

   input  logic                  prf_wr_en  [rs_pkg::IPRF_NUM_WRITES-1:0],
   input  rs_pkg::t_prf_wr_pkt   prf_wr_pkt [rs_pkg::IPRF_NUM_WRITES-1:0],

   input  logic                  grant,

   output logic                  valid,
   output logic                  eligible,
   output rs_pkg::t_rs_alloc_pkt uop
);

   rs_pkg::t_uop_op    op;
   rs_pkg::t_prf_id    pdst;
   rs_pkg::t_rob_id    rob_id;
   rs_pkg::t_src_descr src0, src1;
   logic               ready0, ready1;

   // slot occupancy
   always_ff @(posedge clk) begin
      if (reset) begin
         valid <= 1'b0;
      end else if (alloc) begin
         valid <= 1'b1;
      end else if (grant) begin
         valid <= 1'b0;   // freed at the edge after issue
      end
   end

   always_ff @(posedge clk) begin
      if (alloc) begin
         op     <= alloc_pkt.op;
         pdst   <= alloc_pkt.pdst;
         rob_id <= alloc_pkt.rob_id;
      end
   end

   rs_reg_trk trk0_i (
      .clk        (clk),
      .reset      (reset),
      .alloc      (alloc),
      .alloc_src  (alloc_pkt.src0),
      .prf_wr_en  (prf_wr_en),
      .prf_wr_pkt (prf_wr_pkt),
      .src        (src0),
      .ready      (ready0)
   );

   rs_reg_trk trk1_i (
      .clk        (clk),
      .reset      (reset),
      .alloc      (alloc),
      .alloc_src  (alloc_pkt.src1),
      .prf_wr_en  (prf_wr_en),
      .prf_wr_pkt (prf_wr_pkt),
      .src        (src1),
      .ready      (ready1)
   );

   assign eligible = valid & ready0 & ready1;

   always_comb begin
      uop.op     = op;
      uop.src0   = src0;
      uop.src1   = src1;
      uop.pdst   = pdst;
      uop.rob_id = rob_id;
   end

endmodule

//--- rs_golden.txt
# S alloc op pend0 psrc0 pend1 psrc1 pdst rob wen0 wpdst0 wdata0 wen1 wpdst1 wdata1 (hex)
# E rob op pdst, expected issue order
# ready sources, issue in allocation order
S 1 0 0 01 0 02 10 00 0 00 00000000 0 00 00000000
S 0 0 0 00 0 00 00 00 0 00 00000000 0 00 00000000
S 1 1 0 03 0 04 11 01 0 00 00000000 0 00 00000000
S 1 2 0 05 0 06 12 02 0 00 00000000 0 00 00000000
# pending source, unrelated writeback, then the real one
S 1 3 1 20 0 07 13 03 0 00 00000000 0 00 00000000
S 1 4 0 08 0 09 14 04 1 21 0000abcd 0 00 00000000
S 0 0 0 00 0 00 00 00 0 00 00000000 0 00 00000000
S 0 0 0 00 0 00 00 00 0 00 00000000 1 20 12345678
# writebacks in the allocation cycle
S 1 5 1 22 1 23 15 05 1 22 00000022 1 23 00000023
S 1 0 0 0a 0 0b 16 06 0 00 00000000 0 00 00000000
S 0 0 0 00 0 00 00 00 0 00 00000000 0 00 00000000
# fill all slots with pending micro-ops, credits run out
S 1 0 1 30 0 0c 17 07 0 00 00000000 0 00 00000000
S 1 1 0 0d 1 31 18 08 0 00 00000000 0 00 00000000
S 1 4 1 32 1 33 19 09 0 00 00000000 0 00 00000000
S 1 3 1 34 0 0e 1a 0a 1 32 00000032 1 33 00000033
S 1 2 0 0f 0 01 1b 0b 1 34 00000034 1 30 00000030
S 0 0 0 00 0 00 00 00 1 31 00000031 0 00 00000000
E 00 0 10
E 01 1 11
E 02 2 12
E 04 4 14
E 03 3 13
E 05 5 15
E 06 0 16
E 09 4 19
E 07 0 17
E 08 1 18
E 0b 2 1b
E 0a 3 1a

//--- rs_pick.sv
`timescale 1ns/1ps

module rs_pick (
   input  logic [rs_pkg::RS_NUM_ENTRIES-1:0] eligible,
   input  rs_pkg::t_rs_alloc_pkt             uops [rs_pkg::RS_NUM_ENTRIES-1:0],

   output logic [rs_pkg::RS_NUM_ENTRIES-1:0] grant,
   output logic                              issue_valid,
   output rs_pkg::t_rs_issue_pkt             issue_pkt
);

   // lowest set bit wins
   assign grant       = eligible & (~eligible + 1'b1);
   assign issue_valid = |eligible;

   // grant is one-hot, so at most one slot writes the packet
   always_comb begin
      issue_pkt = '0;
      for (int i = 0; i < rs_pkg::RS_NUM_ENTRIES; i++) begin
         if (grant[i]) begin
            issue_pkt.op     = uops[i].op;
            issue_pkt.psrc0  = uops[i].src0.psrc;   // pending flags dropped
            issue_pkt.psrc1  = uops[i].src1.psrc;
            issue_pkt.pdst   = uops[i].pdst;
            issue_pkt.rob_id = uops[i].rob_id;
         end
      end
   end

endmodule

//--- rs_pkg.sv
package rs_pkg;

   // station geometry
   localparam int RS_NUM_ENTRIES  = 4;
   localparam int IPRF_NUM_WRITES = 2;   // writeback ports into the prf

   localparam int PRF_ID_W = 6;
   localparam int ROB_ID_W = 5;
   localparam int DATA_W   = 32;

   typedef logic [PRF_ID_W-1:0] t_prf_id;
   typedef logic [ROB_ID_W-1:0] t_rob_id;

   typedef enum logic [2:0] {
      OP_ADD = 3'd0,
      OP_SUB = 3'd1,
      OP_AND = 3'd2,
      OP_OR  = 3'd3,
      OP_XOR = 3'd4,
      OP_SLL = 3'd5
   } t_uop_op;

   // per-source tracker state
   typedef enum logic {
      SRC_PDG_RSLT = 1'b0,   // producer has not written back yet
      SRC_READY    = 1'b1
   } t_src_fsm;

   typedef struct packed {
      logic    psrc_pend;   // set when the producer is still in flight
      t_prf_id psrc;
   } t_src_descr;

   // micro-op as handed over by rename
   typedef struct packed {
      t_uop_op    op;
      t_src_descr src0;
      t_src_descr src1;
      t_prf_id    pdst;
      t_rob_id    rob_id;
   } t_rs_alloc_pkt;

   typedef struct packed {
      t_prf_id           pdst;
      logic [DATA_W-1:0] data;
   } t_prf_wr_pkt;

   // pending flags are gone by the time a micro-op issues
   typedef struct packed {
      t_uop_op op;
      t_prf_id psrc0;
      t_prf_id psrc1;
      t_prf_id pdst;
      t_rob_id rob_id;
   } t_rs_issue_pkt;

endpackage

//--- rs_reg_trk.sv
`timescale 1ns/1ps

module rs_reg_trk (
   input  logic               clk,
   input  logic               reset,

   input  logic               alloc,
   input  rs_pkg::t_src_descr alloc_src,

   input  logic               prf_wr_en  [rs_pkg::IPRF_NUM_WRITES-1:0],
   input  rs_pkg::t_prf_wr_pkt prf_wr_pkt [rs_pkg::IPRF_NUM_WRITES-1:0],

   output rs_pkg::t_src_descr src,
   output logic               ready
);

   rs_pkg::t_src_fsm fsm, fsm_nxt;
   rs_pkg::t_src_descr src_nxt;
   logic [rs_pkg::IPRF_NUM_WRITES-1:0] wb_match;
   logic wb_match_any;

   assign src_nxt = alloc ? alloc_src : src;

   always_ff @(posedge clk) begin
      if (alloc) src <= alloc_src;   // descriptor only, no reset needed
   end

   // compare against next-state id so a write in the alloc cycle is caught
   for (genvar p = 0; p < rs_pkg::IPRF_NUM_WRITES; p++) begin : g_wb_match
      assign wb_match[p] = prf_wr_en[p] & (prf_wr_pkt[p].pdst == src_nxt.psrc);
   end
   assign wb_match_any = |wb_match;

   always_comb begin
      fsm_nxt = fsm;
      case (fsm)
         rs_pkg::SRC_READY: begin
            if (alloc & alloc_src.psrc_pend & ~wb_match_any) fsm_nxt = rs_pkg::SRC_PDG_RSLT;
         end
         rs_pkg::SRC_PDG_RSLT: begin
            if (wb_match_any) fsm_nxt = rs_pkg::SRC_READY;
         end
         default: fsm_nxt = rs_pkg::SRC_READY;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) fsm <= rs_pkg::SRC_READY;
      else       fsm <= fsm_nxt;
   end

   assign ready = (fsm == rs_pkg::SRC_READY);

endmodule

//--- rs_tb.sv
`timescale 1ns/1ps

module rs_tb;

   localparam int CLK_PERIOD      = 20;
   localparam int RESET_CYCLES    = 10;
   localparam int CYCLES_PER_LINE = 20;

   // one row of the golden file, driven in one cycle
   typedef struct packed {
      logic                  alloc_valid;
      rs_pkg::t_rs_alloc_pkt pkt;
      logic [1:0]            wr_en;
      rs_pkg::t_prf_wr_pkt   wr0;
      rs_pkg::t_prf_wr_pkt   wr1;
   } t_stim_line;

   typedef struct packed {
      rs_pkg::t_rob_id rob_id;
      rs_pkg::t_uop_op op;
      rs_pkg::t_prf_id pdst;
   } t_exp_issue;

   logic                  clk;
   logic                  reset;
   logic                  alloc_valid;
   rs_pkg::t_rs_alloc_pkt alloc_pkt;
   logic                  prf_wr_en  [rs_pkg::IPRF_NUM_WRITES-1:0];
   rs_pkg::t_prf_wr_pkt   prf_wr_pkt [rs_pkg::IPRF_NUM_WRITES-1:0];
   logic                  issue_valid;
   rs_pkg::t_rs_issue_pkt issue_pkt;
   logic                  credit_return;

   t_stim_line            stim_q [$];
   t_exp_issue            exp_q [$];
   rs_pkg::t_rs_issue_pkt got_q [$];
   rs_pkg::t_rs_alloc_pkt sent_by_rob [2**rs_pkg::ROB_ID_W];   // psrc lookup at issue
   int                    allocs_sent;
   int                    credits_back;
   int                    timeout_cycles;

   rs_top rs_top_i (
      .clk           (clk),
      .reset         (reset),
      .alloc_valid   (alloc_valid),
      .alloc_pkt     (alloc_pkt),
      .prf_wr_en     (prf_wr_en),
      .prf_wr_pkt    (prf_wr_pkt),
      .issue_valid   (issue_valid),
      .issue_pkt     (issue_pkt),
      .credit_return (credit_return)
   );

   always #(CLK_PERIOD/2) clk = ~clk;

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("SOME TESTS FAILED");
      $fatal(1, "run stopped");
   endtask

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp) begin
         abort_run($sformatf("ERR %s got 0x%0h expected 0x%0h", name, got, exp));
      end
   endtask

   task automatic load_golden();
      int         fd;
      int         code;
      int         ch;
      logic [7:0] tag;
      logic [31:0] fld [0:13];
      t_stim_line line;
      t_exp_issue exp;
      fd = $fopen("rs_golden.txt", "r");
      if (fd == 0) begin
         abort_run("could not open rs_golden.txt");
      end
      code = $fscanf(fd, " %c", tag);
      while (code == 1) begin
         if (tag == "#") begin
            ch = $fgetc(fd);
            while (ch != "\n" && ch != -1) ch = $fgetc(fd);
         end else if (tag == "S") begin
            code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                           fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6],
                           fld[7], fld[8], fld[9], fld[10], fld[11], fld[12], fld[13]);
            if (code != 14) abort_run("malformed stimulus row in rs_golden.txt");
            line.alloc_valid    = fld[0][0];
            line.pkt.op         = rs_pkg::t_uop_op'(fld[1][2:0]);
            line.pkt.src0       = {fld[2][0], fld[3][rs_pkg::PRF_ID_W-1:0]};
            line.pkt.src1       = {fld[4][0], fld[5][rs_pkg::PRF_ID_W-1:0]};
            line.pkt.pdst       = fld[6][rs_pkg::PRF_ID_W-1:0];
            line.pkt.rob_id     = fld[7][rs_pkg::ROB_ID_W-1:0];
            line.wr_en[0]       = fld[8][0];
            line.wr0            = {fld[9][rs_pkg::PRF_ID_W-1:0], fld[10]};
            line.wr_en[1]       = fld[11][0];
            line.wr1            = {fld[12][rs_pkg::PRF_ID_W-1:0], fld[13]};
            stim_q.push_back(line);
         end else if (tag == "E") begin
            code = $fscanf(fd, "%h %h %h", fld[0], fld[1], fld[2]);
            if (code != 3) abort_run("malformed expected row in rs_golden.txt");
            exp.rob_id = fld[0][rs_pkg::ROB_ID_W-1:0];
            exp.op     = rs_pkg::t_uop_op'(fld[1][2:0]);
            exp.pdst   = fld[2][rs_pkg::PRF_ID_W-1:0];
            exp_q.push_back(exp);
         end else begin
            abort_run("unknown row tag in rs_golden.txt");
         end
         code = $fscanf(fd, " %c", tag);
      end
      $fclose(fd);
   endtask

   task automatic drive_line(input t_stim_line line);
      alloc_valid   <= line.alloc_valid;
      alloc_pkt     <= line.pkt;
      prf_wr_en[0]  <= line.wr_en[0];
      prf_wr_pkt[0] <= line.wr0;
      prf_wr_en[1]  <= line.wr_en[1];
      prf_wr_pkt[1] <= line.wr1;
   endtask

   task automatic run_stimulus();
      foreach (stim_q[i]) begin
         // no credit left, hold the whole row
         while (stim_q[i].alloc_valid &&
                (allocs_sent - credits_back >= rs_pkg::RS_NUM_ENTRIES)) begin
            drive_line('0);
            @(posedge clk);
         end
         drive_line(stim_q[i]);
         if (stim_q[i].alloc_valid) begin
            allocs_sent++;
            sent_by_rob[stim_q[i].pkt.rob_id] = stim_q[i].pkt;
         end
         @(posedge clk);
      end
      drive_line('0);
   endtask

   task automatic check_issue(input rs_pkg::t_rs_issue_pkt pkt, input int idx);
      t_exp_issue            exp;
      rs_pkg::t_rs_alloc_pkt sent;
      if (idx >= exp_q.size()) begin
         abort_run("a micro-op issued beyond the expected sequence");
      end else begin
         exp  = exp_q[idx];
         sent = sent_by_rob[pkt.rob_id];
         check_value("issue_pkt.rob_id", pkt.rob_id, exp.rob_id);
         check_value("issue_pkt.op", pkt.op, exp.op);
         check_value("issue_pkt.pdst", pkt.pdst, exp.pdst);
         check_value("issue_pkt.psrc0", pkt.psrc0, sent.src0.psrc);
         check_value("issue_pkt.psrc1", pkt.psrc1, sent.src1.psrc);
      end
   endtask

   // outputs settle between edges, sample in the middle
   always @(negedge clk) begin
      if (!reset) begin
         if (credit_return) credits_back++;
         if (issue_valid) begin
            got_q.push_back(issue_pkt);
            check_issue(issue_pkt, got_q.size() - 1);
         end
      end
   end

   initial begin
      clk          = 1'b0;
      reset        = 1'b1;
      alloc_valid  = 1'b0;
      alloc_pkt    = '0;
      foreach (prf_wr_en[p]) begin
         prf_wr_en[p]  = 1'b0;
         prf_wr_pkt[p] = '0;
      end
      allocs_sent  = 0;
      credits_back = 0;
      load_golden();
      timeout_cycles = RESET_CYCLES + CYCLES_PER_LINE * stim_q.size();
      fork
         begin
            repeat (RESET_CYCLES) @(posedge clk);
            reset <= 1'b0;
            run_stimulus();
            while (got_q.size() < exp_q.size()) @(posedge clk);
            repeat (4) @(posedge clk);   // room for a stray extra issue
         end
         begin
            #(timeout_cycles * CLK_PERIOD);
            abort_run("the issue sequence did not complete before the timeout");
         end
      join_any
      disable fork;
      check_value("credit_return count", credits_back, allocs_sent);
      if (got_q.size() == exp_q.size()) begin
         $display("ALL TESTS PASSED");
         $finish;
      end else begin
         abort_run("number of issued micro-ops differs from the expected sequence");
      end
   end

endmodule

//--- rs_top.sv
`timescale 1ns/1ps

module rs_top (
   input  logic                  clk,
   input  logic                  reset,

   // upstream, credit controlled
   input  logic                  alloc_valid,
   input  rs_pkg::t_rs_alloc_pkt alloc_pkt,

   input  logic                  prf_wr_en  [rs_pkg::IPRF_NUM_WRITES-1:0],
   input  rs_pkg::t_prf_wr_pkt   prf_wr_pkt [rs_pkg::IPRF_NUM_WRITES-1:0],

   output logic                  issue_valid,
   output rs_pkg::t_rs_issue_pkt issue_pkt,
   output logic                  credit_return
);

   logic [rs_pkg::RS_NUM_ENTRIES-1:0] entry_valid;
   logic [rs_pkg::RS_NUM_ENTRIES-1:0] entry_eligible;
   logic [rs_pkg::RS_NUM_ENTRIES-1:0] free_slots;
   logic [rs_pkg::RS_NUM_ENTRIES-1:0] alloc_sel;
   logic [rs_pkg::RS_NUM_ENTRIES-1:0] grant;
   rs_pkg::t_rs_alloc_pkt             uops [rs_pkg::RS_NUM_ENTRIES-1:0];

   // lowest invalid slot takes the incoming micro-op
   assign free_slots = ~entry_valid;
   assign alloc_sel  = alloc_valid ? (free_slots & (~free_slots + 1'b1)) : '0;

   for (genvar e = 0; e < rs_pkg::RS_NUM_ENTRIES; e++) begin : g_entry
      rs_entry entry_i (
         .clk        (clk),
         .reset      (reset),
         .alloc      (alloc_sel[e]),
         .alloc_pkt  (alloc_pkt),
         .prf_wr_en  (prf_wr_en),
         .prf_wr_pkt (prf_wr_pkt),
         .grant      (grant[e]),
         .valid      (entry_valid[e]),
         .eligible   (entry_eligible[e]),
         .uop        (uops[e])
      );
   end

   rs_pick pick_i (
      .eligible    (entry_eligible),
      .uops        (uops),
      .grant       (grant),
      .issue_valid (issue_valid),
      .issue_pkt   (issue_pkt)
   );

   // one credit back per issued micro-op, same cycle
   assign credit_return = issue_valid;

endmodule

//--- src.f
rs_pkg.sv
rs_reg_trk.sv
rs_entry.sv
rs_pick.sv
rs_top.sv
rs_chk.sv
rs_tb.sv
